/* src/alut_reg_pkg.sv */
`default_nettype none

package alut_reg_pkg;

   // ------------------------------------------------
   // apb byte offsets
   // ------------------------------------------------
   localparam logic [6:0] al_frm_d_addr_l   = 7'h00;
   localparam logic [6:0] al_frm_d_addr_u   = 7'h04;
   localparam logic [6:0] al_frm_s_addr_l   = 7'h08;
   localparam logic [6:0] al_frm_s_addr_u   = 7'h0c;
   localparam logic [6:0] al_s_port         = 7'h10;
   localparam logic [6:0] al_d_port         = 7'h14;   // read only
   localparam logic [6:0] al_mac_addr_l     = 7'h18;
   localparam logic [6:0] al_mac_addr_u     = 7'h1c;
   localparam logic [6:0] al_cur_time       = 7'h20;   // read only
   localparam logic [6:0] al_bb_age         = 7'h24;
   localparam logic [6:0] al_div_clk        = 7'h28;
   localparam logic [6:0] al_status         = 7'h2c;
   localparam logic [6:0] al_lst_inv_addr_l = 7'h30;
   localparam logic [6:0] al_lst_inv_addr_u = 7'h34;
   localparam logic [6:0] al_lst_inv_port   = 7'h38;
   localparam logic [6:0] al_command        = 7'h3c;   // write only, reads 0

   // status word bits
   localparam int st_active = 0;
   localparam int st_inval  = 1;
   localparam int st_reused = 2;

   // command codes
   localparam logic [1:0] cmd_none  = 2'd0;
   localparam logic [1:0] cmd_check = 2'd1;
   localparam logic [1:0] cmd_age   = 2'd2;

   localparam logic [31:0] bb_age_reset = 32'hffff_ffff;

endpackage

`default_nettype wire

/* src/alut_table_pkg.sv */
`default_nettype none

package alut_table_pkg;

   localparam int alut_depth = 8;   // entries
   localparam int idx_w      = 3;   // low address bits used as index
   localparam int addr_w     = 48;  // mac address
   localparam int port_w     = 2;   // four physical ports
   localparam int time_w     = 32;

   // destination mask, bits 3..0 one-hot port, bit 4 the switch itself
   localparam int dport_w    = 5;

endpackage

`default_nettype wire

/* src/alut_reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_reg_bank
(
   input  logic                                  pclk12,
   input  logic                                  n_p_reset12,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [6:0]                            paddr,
   input  logic [31:0]                           pwdata,
   input  logic [alut_table_pkg::time_w-1:0]     curr_time,
   input  logic                                  add_check_active,
   input  logic                                  age_check_active,
   input  logic                                  inval_in_prog,
   input  logic                                  reused,
   input  logic [alut_table_pkg::dport_w-1:0]    d_port,
   input  logic [alut_table_pkg::addr_w-1:0]     lst_inv_addr_nrm,
   input  logic [alut_table_pkg::port_w-1:0]     lst_inv_port_nrm,
   input  logic [alut_table_pkg::addr_w-1:0]     lst_inv_addr_cmd,
   input  logic [alut_table_pkg::port_w-1:0]     lst_inv_port_cmd,
   output logic [alut_table_pkg::addr_w-1:0]     mac_addr,
   output logic [alut_table_pkg::addr_w-1:0]     d_addr,
   output logic [alut_table_pkg::addr_w-1:0]     s_addr,
   output logic [alut_table_pkg::port_w-1:0]     s_port,
   output logic [31:0]                           best_bfr_age,
   output logic [7:0]                            div_clk,
   output logic [1:0]                            command,
   output logic [31:0]                           prdata,
   output logic                                  clear_reused
);

   logic        read_en;    // setup phase of a read
   logic        write_en;   // access phase of a write
   logic        active;
   logic [31:0] status;
   logic [31:0] frm_d_addr_l, frm_s_addr_l, mac_addr_l;
   logic [15:0] frm_d_addr_u, frm_s_addr_u, mac_addr_u;
   logic [alut_table_pkg::addr_w-1:0] lst_inv_addr;
   logic [alut_table_pkg::port_w-1:0] lst_inv_port;

   assign read_en  = psel & ~penable & ~pwrite;
   assign write_en = psel & penable & pwrite;
   assign active   = add_check_active | age_check_active;

   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};
   assign mac_addr = {mac_addr_u, mac_addr_l};

   // reading status while idle drops the sticky reuse flag
   assign clear_reused = read_en & (paddr == alut_reg_pkg::al_status) & ~active;

   always_comb
   begin
      status = '0;
      status[alut_reg_pkg::st_active] = active;
      status[alut_reg_pkg::st_inval]  = inval_in_prog;
      status[alut_reg_pkg::st_reused] = reused;
   end

   // ------------------------------------------------
   // read mux, data lands in the access phase
   // ------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            alut_reg_pkg::al_frm_d_addr_l   : prdata <= frm_d_addr_l;
            alut_reg_pkg::al_frm_d_addr_u   : prdata <= {16'd0, frm_d_addr_u};
            alut_reg_pkg::al_frm_s_addr_l   : prdata <= frm_s_addr_l;
            alut_reg_pkg::al_frm_s_addr_u   : prdata <= {16'd0, frm_s_addr_u};
            alut_reg_pkg::al_s_port         : prdata <= {30'd0, s_port};
            alut_reg_pkg::al_d_port         : prdata <= {27'd0, d_port};
            alut_reg_pkg::al_mac_addr_l     : prdata <= mac_addr_l;
            alut_reg_pkg::al_mac_addr_u     : prdata <= {16'd0, mac_addr_u};
            alut_reg_pkg::al_cur_time       : prdata <= curr_time;
            alut_reg_pkg::al_bb_age         : prdata <= best_bfr_age;
            alut_reg_pkg::al_div_clk        : prdata <= {24'd0, div_clk};
            alut_reg_pkg::al_status         : prdata <= status;
            alut_reg_pkg::al_lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            alut_reg_pkg::al_lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_reg_pkg::al_lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default                         : prdata <= '0;   // command too
         endcase
      end
      else
         prdata <= '0;
   end

   // ------------------------------------------------
   // writable registers
   // ------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= alut_reg_pkg::bb_age_reset;   // never ages by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            alut_reg_pkg::al_frm_d_addr_l : frm_d_addr_l <= pwdata;
            alut_reg_pkg::al_frm_d_addr_u : frm_d_addr_u <= pwdata[15:0];
            alut_reg_pkg::al_frm_s_addr_l : frm_s_addr_l <= pwdata;
            alut_reg_pkg::al_frm_s_addr_u : frm_s_addr_u <= pwdata[15:0];
            alut_reg_pkg::al_s_port       : s_port       <= pwdata[1:0];
            alut_reg_pkg::al_mac_addr_l   : mac_addr_l   <= pwdata;
            alut_reg_pkg::al_mac_addr_u   : mac_addr_u   <= pwdata[15:0];
            alut_reg_pkg::al_bb_age       : best_bfr_age <= pwdata;
            alut_reg_pkg::al_div_clk      : div_clk      <= pwdata[7:0];
            default                       : ;
         endcase
      end
   end

   // command lives for one cycle only
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         command <= alut_reg_pkg::cmd_none;
      else if (command != alut_reg_pkg::cmd_none)
         command <= alut_reg_pkg::cmd_none;
      else if (write_en & (paddr == alut_reg_pkg::al_command))
         command <= pwdata[1:0];
   end

   // ------------------------------------------------
   // last invalidated entry, reuse beats aging
   // ------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)   // age path holds the latest aged entry
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

endmodule

`default_nettype wire

/* src/alut_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_timer
(
   input  logic                               pclk12,
   input  logic                               n_p_reset12,
   input  logic [7:0]                         div_clk,
   output logic [alut_table_pkg::time_w-1:0]  curr_time
);

   logic [7:0] prescale;   // pclk cycles within one time tick

   // one tick every div_clk+1 cycles, time wraps at 2**32
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         prescale  <= '0;
         curr_time <= '0;
      end
      else if (prescale >= div_clk)   // also catches a divider lowered mid count
      begin
         prescale  <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         prescale <= prescale + 1'b1;
   end

endmodule

`default_nettype wire

/* src/alut_addr_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_addr_checker
(
   input  logic                                pclk12,
   input  logic                                n_p_reset12,
   input  logic [1:0]                          command,
   input  logic                                inval_in_prog,
   input  logic [alut_table_pkg::addr_w-1:0]   d_addr,
   input  logic [alut_table_pkg::addr_w-1:0]   s_addr,
   input  logic [alut_table_pkg::port_w-1:0]   s_port,
   input  logic [alut_table_pkg::addr_w-1:0]   mac_addr,
   input  logic [alut_table_pkg::time_w-1:0]   curr_time,
   input  logic                                clear_reused,
   input  logic                                rd_d_valid,
   input  logic [alut_table_pkg::addr_w-1:0]   rd_d_addr,
   input  logic [alut_table_pkg::port_w-1:0]   rd_d_port,
   input  logic                                rd_s_valid,
   input  logic [alut_table_pkg::addr_w-1:0]   rd_s_addr,
   input  logic [alut_table_pkg::port_w-1:0]   rd_s_port,
   output logic                                add_check_active,
   output logic [alut_table_pkg::dport_w-1:0]  d_port,
   output logic                                reused,
   output logic [alut_table_pkg::addr_w-1:0]   lst_inv_addr_nrm,
   output logic [alut_table_pkg::port_w-1:0]   lst_inv_port_nrm,
   output logic                                wr_en,
   output logic [alut_table_pkg::idx_w-1:0]    wr_idx,
   output logic                                wr_valid,
   output logic [alut_table_pkg::addr_w-1:0]   wr_addr,
   output logic [alut_table_pkg::port_w-1:0]   wr_port,
   output logic [alut_table_pkg::time_w-1:0]   wr_time
);

   logic start, stage1, stage2;
   logic d_hit_q, s_valid_q;
   logic [alut_table_pkg::addr_w-1:0] d_addr_q, s_addr_q;
   logic [alut_table_pkg::port_w-1:0] d_port_q, s_port_q;
   logic [alut_table_pkg::dport_w-1:0] d_port_nxt;
   logic slot_taken;

   // aging scan owns the table, the command is dropped
   assign start = (command == alut_reg_pkg::cmd_check) & ~inval_in_prog;
   assign add_check_active = stage1 | stage2;

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         stage1 <= 1'b0;
         stage2 <= 1'b0;
      end
      else
      begin
         stage1 <= start;
         stage2 <= stage1;
      end
   end

   // ------------------------------------------------
   // stage 1, snapshot both reads
   // ------------------------------------------------
   always_ff @(posedge pclk12)
   begin
      if (stage1)
      begin
         d_hit_q   <= rd_d_valid;
         d_addr_q  <= rd_d_addr;
         d_port_q  <= rd_d_port;
         s_valid_q <= rd_s_valid;
         s_addr_q  <= rd_s_addr;
         s_port_q  <= rd_s_port;
      end
   end

   // ------------------------------------------------
   // stage 2, decide mask and learn
   // ------------------------------------------------
   always_comb
   begin
      if (d_addr == mac_addr)
         d_port_nxt = 5'b1_0000;   // for the switch itself
      else if (d_hit_q && (d_addr_q == d_addr))
         d_port_nxt = 5'b0_0001 << d_port_q;
      else
         d_port_nxt = {1'b0, ~(4'b0001 << s_port)};   // flood, not back out
   end

   assign slot_taken = s_valid_q & (s_addr_q != s_addr);

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         d_port <= '0;
         reused <= 1'b0;
      end
      else if (stage2)
      begin
         d_port <= d_port_nxt;
         if (slot_taken)
            reused <= 1'b1;
      end
      else if (clear_reused)
         reused <= 1'b0;
   end

   // evicted entry, shown while reused is up
   always_ff @(posedge pclk12)
   begin
      if (stage2 && slot_taken)
      begin
         lst_inv_addr_nrm <= s_addr_q;
         lst_inv_port_nrm <= s_port_q;
      end
   end

   assign wr_en    = stage2;
   assign wr_idx   = s_addr[alut_table_pkg::idx_w-1:0];
   assign wr_valid = 1'b1;
   assign wr_addr  = s_addr;
   assign wr_port  = s_port;
   assign wr_time  = curr_time;

endmodule

`default_nettype wire

/* src/alut_age_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_age_checker
(
   input  logic                               pclk12,
   input  logic                               n_p_reset12,
   input  logic [1:0]                         command,
   input  logic                               add_check_active,
   input  logic [31:0]                        best_bfr_age,
   input  logic [alut_table_pkg::time_w-1:0]  curr_time,
   input  logic                               rd_valid,
   input  logic [alut_table_pkg::addr_w-1:0]  rd_addr,
   input  logic [alut_table_pkg::port_w-1:0]  rd_port,
   input  logic [alut_table_pkg::time_w-1:0]  rd_time,
   output logic                               age_check_active,
   output logic                               inval_in_prog,
   output logic [alut_table_pkg::idx_w-1:0]   scan_idx,
   output logic [alut_table_pkg::addr_w-1:0]  lst_inv_addr_cmd,
   output logic [alut_table_pkg::port_w-1:0]  lst_inv_port_cmd,
   output logic                               wr_en,
   output logic [alut_table_pkg::idx_w-1:0]   wr_idx
);

   logic scanning;
   logic aged;
   logic [alut_table_pkg::time_w-1:0] age;   // modulo 2**32
   logic [alut_table_pkg::addr_w-1:0] held_addr;
   logic [alut_table_pkg::port_w-1:0] held_port;

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         scanning <= 1'b0;
         scan_idx <= '0;
      end
      else if (!scanning)
      begin
         scanning <= (command == alut_reg_pkg::cmd_age) & ~add_check_active;
         scan_idx <= '0;
      end
      else
      begin
         scan_idx <= scan_idx + 1'b1;
         if (scan_idx == alut_table_pkg::idx_w'(alut_table_pkg::alut_depth - 1))
            scanning <= 1'b0;   // last entry visited
      end
   end

   assign age_check_active = scanning;
   assign inval_in_prog    = scanning;

   assign age  = curr_time - rd_time;
   assign aged = scanning & rd_valid & (age > best_bfr_age);

   assign wr_en  = aged;   // table clears valid only
   assign wr_idx = scan_idx;

   always_ff @(posedge pclk12)
   begin
      if (aged)
      begin
         held_addr <= rd_addr;
         held_port <= rd_port;
      end
   end

   // current victim, else the last one already taken
   assign lst_inv_addr_cmd = aged ? rd_addr : held_addr;
   assign lst_inv_port_cmd = aged ? rd_port : held_port;

endmodule

`default_nettype wire

/* src/alut_table.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_table
(
   input  logic                               pclk12,
   input  logic                               n_p_reset12,
   input  logic [alut_table_pkg::idx_w-1:0]   rd_d_idx,
   input  logic [alut_table_pkg::idx_w-1:0]   rd_s_idx,
   input  logic [alut_table_pkg::idx_w-1:0]   scan_idx,
   input  logic                               addr_wr_en,
   input  logic [alut_table_pkg::idx_w-1:0]   addr_wr_idx,
   input  logic                               addr_wr_valid,
   input  logic [alut_table_pkg::addr_w-1:0]  addr_wr_addr,
   input  logic [alut_table_pkg::port_w-1:0]  addr_wr_port,
   input  logic [alut_table_pkg::time_w-1:0]  addr_wr_time,
   input  logic                               age_wr_en,
   input  logic [alut_table_pkg::idx_w-1:0]   age_wr_idx,
   output logic                               rd_d_valid,
   output logic [alut_table_pkg::addr_w-1:0]  rd_d_addr,
   output logic [alut_table_pkg::port_w-1:0]  rd_d_port,
   output logic                               rd_s_valid,
   output logic [alut_table_pkg::addr_w-1:0]  rd_s_addr,
   output logic [alut_table_pkg::port_w-1:0]  rd_s_port,
   output logic                               scan_valid,
   output logic [alut_table_pkg::addr_w-1:0]  scan_addr,
   output logic [alut_table_pkg::port_w-1:0]  scan_port,
   output logic [alut_table_pkg::time_w-1:0]  scan_time
);

   logic [alut_table_pkg::alut_depth-1:0] valid;
   logic [alut_table_pkg::addr_w-1:0] addr_mem [alut_table_pkg::alut_depth];
   logic [alut_table_pkg::port_w-1:0] port_mem [alut_table_pkg::alut_depth];
   logic [alut_table_pkg::time_w-1:0] time_mem [alut_table_pkg::alut_depth];

   // learning write wins over an aging clear
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         valid <= '0;
      else
      begin
         if (age_wr_en)
            valid[age_wr_idx] <= 1'b0;
         if (addr_wr_en)
            valid[addr_wr_idx] <= addr_wr_valid;
      end
   end

   always_ff @(posedge pclk12)
   begin
      if (addr_wr_en)
      begin
         addr_mem[addr_wr_idx] <= addr_wr_addr;
         port_mem[addr_wr_idx] <= addr_wr_port;
         time_mem[addr_wr_idx] <= addr_wr_time;
      end
   end

   // three combinational read ports
   assign rd_d_valid = valid[rd_d_idx];
   assign rd_d_addr  = addr_mem[rd_d_idx];
   assign rd_d_port  = port_mem[rd_d_idx];
   assign rd_s_valid = valid[rd_s_idx];
   assign rd_s_addr  = addr_mem[rd_s_idx];
   assign rd_s_port  = port_mem[rd_s_idx];
   assign scan_valid = valid[scan_idx];
   assign scan_addr  = addr_mem[scan_idx];
   assign scan_port  = port_mem[scan_idx];
   assign scan_time  = time_mem[scan_idx];

endmodule

`default_nettype wire

/* src/alut_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_top
(
   input  logic                                pclk12,
   input  logic                                n_p_reset12,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [6:0]                          paddr,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic [alut_table_pkg::dport_w-1:0]  d_port,
   output logic [alut_table_pkg::time_w-1:0]   curr_time
);

   logic [alut_table_pkg::addr_w-1:0] mac_addr, d_addr, s_addr;
   logic [alut_table_pkg::port_w-1:0] s_port;
   logic [31:0] best_bfr_age;
   logic [7:0]  div_clk;
   logic [1:0]  command;
   logic        clear_reused, reused;
   logic        add_check_active, age_check_active, inval_in_prog;
   logic [alut_table_pkg::addr_w-1:0] lst_inv_addr_nrm, lst_inv_addr_cmd;
   logic [alut_table_pkg::port_w-1:0] lst_inv_port_nrm, lst_inv_port_cmd;
   // table side
   logic        a_wr_en, a_wr_valid, g_wr_en;
   logic [alut_table_pkg::idx_w-1:0]  a_wr_idx, g_wr_idx, scan_idx;
   logic [alut_table_pkg::addr_w-1:0] a_wr_addr, rd_d_addr, rd_s_addr, scan_addr;
   logic [alut_table_pkg::port_w-1:0] a_wr_port, rd_d_port, rd_s_port, scan_port;
   logic [alut_table_pkg::time_w-1:0] a_wr_time, scan_time;
   logic        rd_d_valid, rd_s_valid, scan_valid;

   alut_reg_bank reg_bank_i (.*);

   alut_timer timer_i (.pclk12, .n_p_reset12, .div_clk, .curr_time);

   alut_addr_checker addr_checker_i (.*, .wr_en(a_wr_en), .wr_idx(a_wr_idx),
      .wr_valid(a_wr_valid), .wr_addr(a_wr_addr), .wr_port(a_wr_port),
      .wr_time(a_wr_time));

   alut_age_checker age_checker_i (.*, .rd_valid(scan_valid), .rd_addr(scan_addr),
      .rd_port(scan_port), .rd_time(scan_time), .wr_en(g_wr_en), .wr_idx(g_wr_idx));

   alut_table table_i (.*, .rd_d_idx(d_addr[alut_table_pkg::idx_w-1:0]),
      .rd_s_idx(s_addr[alut_table_pkg::idx_w-1:0]),
      .addr_wr_en(a_wr_en), .addr_wr_idx(a_wr_idx), .addr_wr_valid(a_wr_valid),
      .addr_wr_addr(a_wr_addr), .addr_wr_port(a_wr_port), .addr_wr_time(a_wr_time),
      .age_wr_en(g_wr_en), .age_wr_idx(g_wr_idx));

endmodule

`default_nettype wire

/* bench/alut_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alut_tb;

   localparam int clk_half        = 2;    // 4 ns period
   localparam int drive_skew      = 1;    // inputs move 1 ns after the edge
   localparam int reset_cycles    = 5;
   localparam int cycles_per_line = 80;   // watchdog budget per pattern line
   localparam int max_polls       = 64;

   logic        pclk12;
   logic        n_p_reset12;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic [alut_table_pkg::dport_w-1:0] d_port;
   logic [alut_table_pkg::time_w-1:0]  curr_time;

   // one entry per pattern line
   string       op_q[$];
   logic [6:0]  off_q[$];
   logic [31:0] val_q[$];
   logic [31:0] mask_q[$];
   string       name_q[$];
   bit          loaded;

   alut_top dut_i
   (
      .pclk12      (pclk12),
      .n_p_reset12 (n_p_reset12),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .d_port      (d_port),
      .curr_time   (curr_time)
   );

   // ------------------------------------------------
   // helpers
   // ------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic step_cycle();
      @(posedge pclk12);
      #drive_skew;   // away from the edge
   endtask

   // setup then access with the bus idle on return
   task automatic write_reg(input logic [6:0] off, input logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = off;
      pwdata  = data;
      step_cycle();
      penable = 1'b1;   // register loads at the end of this cycle
      step_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_reg(input logic [6:0] off, output logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = off;
      step_cycle();
      penable = 1'b1;
      data    = prdata;   // registered at the end of setup
      step_cycle();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic compare_read(input string name, input logic [6:0] off,
                               input logic [31:0] exp, input logic [31:0] mask);
      logic [31:0] act;
      read_reg(off, act);
      assert ((act & mask) == (exp & mask))
      else
         abort_run($sformatf("Error %s expected %08h actual %08h",
                             name, exp & mask, act & mask));
      // mask pin mirrors the d_port register
      if (off == alut_reg_pkg::al_d_port)
      begin
         assert (d_port == exp[alut_table_pkg::dport_w-1:0])
         else
            abort_run($sformatf("Error %s d_port output expected %02h actual %02h",
                                name, exp[alut_table_pkg::dport_w-1:0], d_port));
      end
   endtask

   // polls with an idle cycle in front of every read
   task automatic poll_until_clear(input string name, input logic [6:0] off,
                                   input logic [31:0] mask, input logic [31:0] final_exp);
      logic [31:0] act;
      int          polls;
      step_cycle();
      read_reg(off, act);
      polls = 1;
      while (((act & mask) != 0) && (polls < max_polls))
      begin
         step_cycle();
         read_reg(off, act);
         polls++;
      end
      assert ((act & mask) == 0)
      else
         abort_run($sformatf("%s: status never cleared, bits %08h still set after %0d reads",
                             name, act & mask, max_polls));
      // last read taken with the checker idle
      assert (act == final_exp)
      else
         abort_run($sformatf("Error %s expected %08h actual %08h", name, final_exp, act));
   endtask

   // each read spans two cycles and the gap makes up the rest
   task automatic measure_time(input string name, input logic [6:0] off,
                               input logic [31:0] exp_delta);
      logic [31:0] first;
      logic [31:0] second;
      logic [alut_table_pkg::time_w-1:0] pin_first;
      logic [alut_table_pkg::time_w-1:0] pin_second;
      int          gap;
      gap = int'(exp_delta) - 2;
      pin_first = curr_time;   // time pin in the first setup cycle
      read_reg(off, first);
      repeat (gap) step_cycle();
      pin_second = curr_time;
      read_reg(off, second);
      assert ((second - first) == exp_delta)
      else
         abort_run($sformatf("Error %s expected %08h actual %08h",
                             name, exp_delta, second - first));
      assert ((pin_second - pin_first) == exp_delta)
      else
         abort_run($sformatf("Error %s curr_time output expected %08h actual %08h",
                             name, exp_delta, pin_second - pin_first));
   endtask

   task automatic load_patterns();
      int               fd;
      int               code;
      string            op;
      string            name;
      logic [6:0]       off;
      logic [31:0]      val;
      logic [31:0]      mask;
      logic [8*160-1:0] rest;
      fd = $fopen("bench/alut_patterns.txt", "r");
      if (fd == 0)
         abort_run("cannot open the pattern file bench/alut_patterns.txt");
      while (!$feof(fd))
      begin
         code = $fscanf(fd, "%s", op);
         if (code != 1)
            break;   // end of file
         if (op.substr(0, 0) == "#")
            code = $fgets(rest, fd);   // skip comment text
         else
         begin
            code = $fscanf(fd, "%h %h %h %s", off, val, mask, name);
            if (code != 4)
               abort_run($sformatf("malformed pattern line starting with %s", op));
            op_q.push_back(op);
            off_q.push_back(off);
            val_q.push_back(val);
            mask_q.push_back(mask);
            name_q.push_back(name);
         end
      end
      $fclose(fd);
      if (op_q.size() == 0)
         abort_run("the pattern file holds no operations");
   endtask

   // ------------------------------------------------
   // clock, stimulus, watchdog
   // ------------------------------------------------
   initial
   begin
      pclk12 = 1'b0;
      forever #clk_half pclk12 = ~pclk12;
   end

   initial
   begin
      n_p_reset12 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      loaded      = 1'b0;
      load_patterns();
      loaded = 1'b1;
      repeat (reset_cycles) @(posedge pclk12);
      #drive_skew;
      n_p_reset12 = 1'b1;
      step_cycle();
      foreach (op_q[i])
      begin
         if (op_q[i] == "W")
            write_reg(off_q[i], val_q[i]);
         else if (op_q[i] == "R")
            compare_read(name_q[i], off_q[i], val_q[i], mask_q[i]);
         else if (op_q[i] == "P")
            poll_until_clear(name_q[i], off_q[i], mask_q[i], val_q[i]);
         else if (op_q[i] == "T")
            measure_time(name_q[i], off_q[i], val_q[i]);
         else
            abort_run($sformatf("unknown pattern operation %s in %s", op_q[i], name_q[i]));
      end
      $display("Finished with no errors");
      $finish;
   end

   initial
   begin
      wait (loaded);
      repeat (op_q.size() * cycles_per_line + reset_cycles) @(posedge pclk12);
      abort_run("watchdog expired before the pattern run completed");
   end

endmodule

`default_nettype wire

/* bench/alut_patterns.txt */
# op offset value mask name, all numbers hex
# W write value, R check value under mask, P poll until mask clear then check value, T time delta
# reset values
R 00 00000000 ffffffff rst_d_addr_l
R 04 00000000 ffffffff rst_d_addr_u
R 08 00000000 ffffffff rst_s_addr_l
R 0c 00000000 ffffffff rst_s_addr_u
R 10 00000000 ffffffff rst_s_port
R 14 00000000 ffffffff rst_d_port
R 18 00000000 ffffffff rst_mac_l
R 1c 00000000 ffffffff rst_mac_u
R 24 ffffffff ffffffff rst_bb_age
R 28 00000000 ffffffff rst_div_clk
R 2c 00000000 ffffffff rst_status
R 30 00000000 ffffffff rst_inv_addr_l
R 34 00000000 ffffffff rst_inv_addr_u
R 38 00000000 ffffffff rst_inv_port
R 3c 00000000 ffffffff rst_command
# register readback
W 00 12345678 0 wr_d_addr_l
R 00 12345678 ffffffff rb_d_addr_l
W 04 ffffabcd 0 wr_d_addr_u
R 04 0000abcd ffffffff rb_d_addr_u
W 0c 5555aaaa 0 wr_s_addr_u
R 0c 0000aaaa ffffffff rb_s_addr_u
W 10 00000003 0 wr_s_port
R 10 00000003 ffffffff rb_s_port
W 28 0000005a 0 wr_div_clk
R 28 0000005a ffffffff rb_div_clk
W 24 00001234 0 wr_bb_age
R 24 00001234 ffffffff rb_bb_age
W 3c 00000000 0 wr_command
R 3c 00000000 ffffffff rb_command
W 28 00000000 0 restore_div_clk
W 24 ffffffff 0 restore_bb_age
# learn a on port 1 at index 1
W 18 00bb00c7 0 wr_mac_l
W 1c 000000aa 0 wr_mac_u
W 08 0c0d0e01 0 wr_s_a_l
W 0c 00000a0b 0 wr_s_a_u
W 10 00000001 0 wr_s_port_1
W 3c 00000001 0 cmd_learn_a
P 2c 00000000 1 learn_a_done
R 14 0000000d ffffffff learn_a_flood
# learn b on port 3 at index 3
W 08 1c1d1e03 0 wr_s_b_l
W 0c 00001a1b 0 wr_s_b_u
W 10 00000003 0 wr_s_port_3
W 3c 00000001 0 cmd_learn_b
P 2c 00000000 1 learn_b_done
R 14 00000007 ffffffff learn_b_flood
# look up a
W 00 0c0d0e01 0 wr_d_a_l
W 04 00000a0b 0 wr_d_a_u
W 3c 00000001 0 cmd_lookup_a
P 2c 00000000 1 lookup_a_done
R 14 00000002 ffffffff lookup_a
# look up b with a as source
W 00 1c1d1e03 0 wr_d_b_l
W 04 00001a1b 0 wr_d_b_u
W 08 0c0d0e01 0 wr_s_a_l
W 0c 00000a0b 0 wr_s_a_u
W 10 00000001 0 wr_s_port_1
W 3c 00000001 0 cmd_lookup_b
P 2c 00000000 1 lookup_b_done
R 14 00000008 ffffffff lookup_b
# unknown destination
W 00 55667704 0 wr_d_unknown_l
W 04 00000000 0 wr_d_unknown_u
W 3c 00000001 0 cmd_unknown
P 2c 00000000 1 unknown_done
R 14 0000000d ffffffff unknown_flood
# own mac
W 00 00bb00c7 0 wr_d_mac_l
W 04 000000aa 0 wr_d_mac_u
W 3c 00000001 0 cmd_own_mac
P 2c 00000000 1 own_mac_done
R 14 00000010 ffffffff own_mac
# c on port 2 replaces a at index 1
W 08 2c2d2e09 0 wr_s_c_l
W 0c 00002a2b 0 wr_s_c_u
W 10 00000002 0 wr_s_port_2
W 3c 00000001 0 cmd_reuse
P 2c 00000004 1 reuse_set
R 2c 00000000 ffffffff reuse_cleared
R 30 0c0d0e01 ffffffff reuse_inv_addr_l
R 34 00000a0b ffffffff reuse_inv_addr_u
R 38 00000001 ffffffff reuse_inv_port
# aging with zero best before age
W 24 00000000 0 wr_bb_age_zero
W 3c 00000002 0 cmd_age
P 2c 00000000 2 age_done
R 30 1c1d1e03 ffffffff age_inv_addr_l
R 34 00001a1b ffffffff age_inv_addr_u
R 38 00000003 ffffffff age_inv_port
# b is gone, source c on port 2
W 00 1c1d1e03 0 wr_d_b_l
W 04 00001a1b 0 wr_d_b_u
W 3c 00000001 0 cmd_aged_lookup
P 2c 00000000 1 aged_lookup_done
R 14 0000000b ffffffff aged_lookup
# timer ticks every cycle with div_clk 0
T 20 00000002 0 time_back_to_back
T 20 00000007 0 time_with_gap

/* src.f */
src/alut_reg_pkg.sv
src/alut_table_pkg.sv
src/alut_reg_bank.sv
src/alut_timer.sv
src/alut_addr_checker.sv
src/alut_age_checker.sv
src/alut_table.sv
src/alut_top.sv
bench/alut_tb.sv

/* Bender.yml */
package:
  name: alut

sources:
  - src/alut_reg_pkg.sv
  - src/alut_table_pkg.sv
  - src/alut_reg_bank.sv
  - src/alut_timer.sv
  - src/alut_addr_checker.sv
  - src/alut_age_checker.sv
  - src/alut_table.sv
  - src/alut_top.sv
  - target: simulation
    files:
      - bench/alut_tb.sv
